// ==== design/i2c_regmap_pkg.sv ====
package i2c_regmap_pkg;

  localparam int REG_W = 8;  // every register is one byte wide

  // configuration registers
  localparam logic [7:0] REG_DEV_ADDR  = 8'h00;
  localparam logic [7:0] REG_ENABLE    = 8'h01;
  localparam logic [7:0] REG_DEBOUNCE  = 8'h02;
  localparam logic [7:0] REG_SCL_DELAY = 8'h03;
  localparam logic [7:0] REG_SDA_DELAY = 8'h04;

  // single byte mailboxes
  localparam logic [7:0] REG_MSG_TO_HOST      = 8'h10;
  localparam logic [7:0] REG_MSG_TO_HOST_STAT = 8'h11;
  localparam logic [7:0] REG_MSG_TO_DEV       = 8'h12;
  localparam logic [7:0] REG_MSG_TO_DEV_STAT  = 8'h13;

  // interrupt status / enable, one pair per side
  localparam logic [7:0] REG_DEV_IRQ_STAT  = 8'h40;
  localparam logic [7:0] REG_DEV_IRQ_EN    = 8'h41;
  localparam logic [7:0] REG_HOST_IRQ_STAT = 8'h50;
  localparam logic [7:0] REG_HOST_IRQ_EN   = 8'h51;

  localparam logic [6:0]       DEFAULT_DEV_ADDR  = 7'h6F;
  localparam logic [REG_W-1:0] DEFAULT_DEBOUNCE  = 8'd20;
  localparam logic [REG_W-1:0] DEFAULT_SCL_DELAY = 8'd20;
  localparam logic [REG_W-1:0] DEFAULT_SDA_DELAY = 8'd8;

  // settings handed to the i2c engine
  typedef struct packed {
    logic [6:0]       dev_addr;
    logic             enable;
    logic [REG_W-1:0] debounce;   // input filter length
    logic [REG_W-1:0] scl_delay;
    logic [REG_W-1:0] sda_delay;  // hold time after scl fall
  } i2c_cfg_t;

  localparam i2c_cfg_t RESET_CFG = '{
    dev_addr:  DEFAULT_DEV_ADDR,
    enable:    1'b0,
    debounce:  DEFAULT_DEBOUNCE,
    scl_delay: DEFAULT_SCL_DELAY,
    sda_delay: DEFAULT_SDA_DELAY
  };

endpackage

// ==== design/i2c_port_pkg.sv ====
package i2c_port_pkg;

  localparam int HOST_ADDR_W = 12;

  typedef logic [HOST_ADDR_W-1:0] host_addr_t;

  // host side, word addressed
  typedef struct packed {
    host_addr_t  waddr;
    logic [31:0] wdata;
    logic        we;
    host_addr_t  raddr;
    logic        rd_done;  // raddr byte has been consumed
  } host_req_t;

  // device side, byte addressed, one address for both directions
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] wdata;
    logic       we;
    logic       rd_done;
  } dev_req_t;

  // decoded writes of one side
  typedef struct packed {
    logic       dev_addr;
    logic       enable;
    logic       debounce;
    logic       scl_delay;
    logic       sda_delay;
    logic       msg;     // this side's outgoing mailbox
    logic       irq_en;  // this side's interrupt enable
    logic [7:0] data;
  } wr_strobe_t;

  typedef struct packed {
    logic host;
    logic dev;
  } rd_done_t;

  // everything either side can read back
  typedef struct packed {
    i2c_regmap_pkg::i2c_cfg_t cfg;
    logic [7:0]               msg_to_host;
    logic [7:0]               msg_to_dev;
    logic                     to_host_full;
    logic                     to_dev_full;
    logic                     host_irq_en;
    logic                     dev_irq_en;
    logic                     host_irq_stat;
    logic                     dev_irq_stat;
  } reg_view_t;

  // byte read mux, shared by both ports
  function automatic logic [7:0] view_byte(reg_view_t v, logic [7:0] idx);
    logic [7:0] b;
    case (idx)
      i2c_regmap_pkg::REG_DEV_ADDR:         b = {1'b0, v.cfg.dev_addr};
      i2c_regmap_pkg::REG_ENABLE:           b = {7'b0, v.cfg.enable};
      i2c_regmap_pkg::REG_DEBOUNCE:         b = v.cfg.debounce;
      i2c_regmap_pkg::REG_SCL_DELAY:        b = v.cfg.scl_delay;
      i2c_regmap_pkg::REG_SDA_DELAY:        b = v.cfg.sda_delay;
      i2c_regmap_pkg::REG_MSG_TO_HOST:      b = v.msg_to_host;
      i2c_regmap_pkg::REG_MSG_TO_HOST_STAT: b = {7'b0, v.to_host_full};
      i2c_regmap_pkg::REG_MSG_TO_DEV:       b = v.msg_to_dev;
      i2c_regmap_pkg::REG_MSG_TO_DEV_STAT:  b = {7'b0, v.to_dev_full};
      i2c_regmap_pkg::REG_DEV_IRQ_STAT:     b = {7'b0, v.dev_irq_stat};
      i2c_regmap_pkg::REG_DEV_IRQ_EN:       b = {7'b0, v.dev_irq_en};
      i2c_regmap_pkg::REG_HOST_IRQ_STAT:    b = {7'b0, v.host_irq_stat};
      i2c_regmap_pkg::REG_HOST_IRQ_EN:      b = {7'b0, v.host_irq_en};
      default:                              b = 8'h00;  // unmapped
    endcase
    return b;
  endfunction

endpackage

// ==== design/msg_mailbox.sv ====
`timescale 1ns/1ps

module msg_mailbox (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wr_i,
  input  logic [i2c_regmap_pkg::REG_W-1:0] wdata_i,
  input  logic                             rd_done_i,
  output logic [i2c_regmap_pkg::REG_W-1:0] data_o,
  output logic                             full_o
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_o <= '0;
      full_o <= 1'b0;
    end else begin
      if (wr_i) begin
        data_o <= wdata_i;  // overwrite if still full
        full_o <= 1'b1;
      end else if (rd_done_i) begin
        full_o <= 1'b0;
      end
    end
  end

endmodule

// ==== design/host_port.sv ====
`timescale 1ns/1ps

module host_port (
  input  logic                    clk,
  input  logic                    rst,
  input  i2c_port_pkg::host_req_t host_req_i,
  input  i2c_port_pkg::reg_view_t view_i,
  output i2c_port_pkg::wr_strobe_t strobe_o,
  output logic                    rd_done_o,
  output logic [31:0]             rdata_o
);

  logic       wr_in_range;
  logic       rd_in_range;
  logic [7:0] widx;  // word index of the write
  logic [7:0] ridx;
  logic [7:0] rd_byte;

  // upper address bits must be clear
  assign wr_in_range = host_req_i.waddr[i2c_port_pkg::HOST_ADDR_W-1:10] == 2'b00;
  assign rd_in_range = host_req_i.raddr[i2c_port_pkg::HOST_ADDR_W-1:10] == 2'b00;

  assign widx = host_req_i.waddr[9:2];
  assign ridx = host_req_i.raddr[9:2];

  // host owns config, msg to device and its own irq enable
  always_comb begin
    strobe_o      = '0;
    strobe_o.data = host_req_i.wdata[7:0];
    if (host_req_i.we && wr_in_range) begin
      case (widx)
        i2c_regmap_pkg::REG_DEV_ADDR:    strobe_o.dev_addr  = 1'b1;
        i2c_regmap_pkg::REG_ENABLE:      strobe_o.enable    = 1'b1;
        i2c_regmap_pkg::REG_DEBOUNCE:    strobe_o.debounce  = 1'b1;
        i2c_regmap_pkg::REG_SCL_DELAY:   strobe_o.scl_delay = 1'b1;
        i2c_regmap_pkg::REG_SDA_DELAY:   strobe_o.sda_delay = 1'b1;
        i2c_regmap_pkg::REG_MSG_TO_DEV:  strobe_o.msg       = 1'b1;
        i2c_regmap_pkg::REG_HOST_IRQ_EN: strobe_o.irq_en    = 1'b1;
        default: ;  // status and unmapped, dropped
      endcase
    end
  end

  // message consumed only on an exact, aligned hit
  assign rd_done_o = host_req_i.rd_done && rd_in_range &&
                     (ridx == i2c_regmap_pkg::REG_MSG_TO_HOST) &&
                     (host_req_i.raddr[1:0] == 2'b00);

  assign rd_byte = rd_in_range ? i2c_port_pkg::view_byte(view_i, ridx) : 8'h00;

  // one cycle read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= {24'b0, rd_byte};
    end
  end

endmodule

// ==== design/dev_port.sv ====
`timescale 1ns/1ps

module dev_port (
  input  logic                     clk,
  input  logic                     rst,
  input  i2c_port_pkg::dev_req_t   dev_req_i,
  input  i2c_port_pkg::reg_view_t  view_i,
  output i2c_port_pkg::wr_strobe_t strobe_o,
  output logic                     rd_done_o,
  output logic [7:0]               rdata_o
);

  logic [7:0] rd_byte;

  // device may only post a message and set its own irq enable
  always_comb begin
    strobe_o      = '0;
    strobe_o.data = dev_req_i.wdata;
    if (dev_req_i.we) begin
      case (dev_req_i.addr)
        i2c_regmap_pkg::REG_MSG_TO_HOST: strobe_o.msg    = 1'b1;
        i2c_regmap_pkg::REG_DEV_IRQ_EN:  strobe_o.irq_en = 1'b1;
        default: ;
      endcase
    end
  end

  assign rd_done_o = dev_req_i.rd_done &&
                     (dev_req_i.addr == i2c_regmap_pkg::REG_MSG_TO_DEV);

  assign rd_byte = i2c_port_pkg::view_byte(view_i, dev_req_i.addr);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= rd_byte;  // valid the cycle after addr
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  i2c_port_pkg::wr_strobe_t  host_strobe_i,
  input  i2c_port_pkg::wr_strobe_t  dev_strobe_i,
  input  logic                      host_rd_done_i,
  input  logic                      dev_rd_done_i,
  output i2c_port_pkg::reg_view_t   view_o,
  output i2c_regmap_pkg::i2c_cfg_t  cfg_o,
  output logic                      host_irq_o,
  output logic                      dev_irq_o
);

  i2c_regmap_pkg::i2c_cfg_t cfg_q;
  logic                     host_irq_en_q;
  logic                     dev_irq_en_q;
  logic [7:0]               to_host_data;
  logic [7:0]               to_dev_data;
  logic                     to_host_full;
  logic                     to_dev_full;

  // config is host only, each irq enable belongs to its own side
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cfg_q         <= i2c_regmap_pkg::RESET_CFG;
      host_irq_en_q <= 1'b0;
      dev_irq_en_q  <= 1'b0;
    end else begin
      if (host_strobe_i.dev_addr)  cfg_q.dev_addr  <= host_strobe_i.data[6:0];
      if (host_strobe_i.enable)    cfg_q.enable    <= host_strobe_i.data[0];
      if (host_strobe_i.debounce)  cfg_q.debounce  <= host_strobe_i.data;
      if (host_strobe_i.scl_delay) cfg_q.scl_delay <= host_strobe_i.data;
      if (host_strobe_i.sda_delay) cfg_q.sda_delay <= host_strobe_i.data;
      if (host_strobe_i.irq_en)    host_irq_en_q   <= host_strobe_i.data[0];
      if (dev_strobe_i.irq_en)     dev_irq_en_q    <= dev_strobe_i.data[0];
    end
  end

  // device posts, host consumes
  msg_mailbox u_to_host (
    .clk       (clk),
    .rst       (rst),
    .wr_i      (dev_strobe_i.msg),
    .wdata_i   (dev_strobe_i.data),
    .rd_done_i (host_rd_done_i),
    .data_o    (to_host_data),
    .full_o    (to_host_full)
  );

  // host posts, device consumes
  msg_mailbox u_to_dev (
    .clk       (clk),
    .rst       (rst),
    .wr_i      (host_strobe_i.msg),
    .wdata_i   (host_strobe_i.data),
    .rd_done_i (dev_rd_done_i),
    .data_o    (to_dev_data),
    .full_o    (to_dev_full)
  );

  assign host_irq_o = to_host_full & host_irq_en_q;
  assign dev_irq_o  = to_dev_full & dev_irq_en_q;

  assign cfg_o = cfg_q;

  always_comb begin
    view_o               = '0;
    view_o.cfg           = cfg_q;
    view_o.msg_to_host   = to_host_data;
    view_o.msg_to_dev    = to_dev_data;
    view_o.to_host_full  = to_host_full;
    view_o.to_dev_full   = to_dev_full;
    view_o.host_irq_en   = host_irq_en_q;
    view_o.dev_irq_en    = dev_irq_en_q;
    view_o.host_irq_stat = host_irq_o;  // status is the gated flag
    view_o.dev_irq_stat  = dev_irq_o;
  end

endmodule

// ==== design/i2c_periph_regs_top.sv ====
`timescale 1ns/1ps

module i2c_periph_regs_top (
  input  logic                     clk,
  input  logic                     rst,
  input  i2c_port_pkg::host_req_t  host_req_i,
  output logic [31:0]              host_rdata_o,
  input  i2c_port_pkg::dev_req_t   dev_req_i,
  output logic [7:0]               dev_rdata_o,
  output i2c_regmap_pkg::i2c_cfg_t cfg_o,
  output logic                     host_irq_o,
  output logic                     i2c_irq_o
);

  i2c_port_pkg::wr_strobe_t host_strobe;
  i2c_port_pkg::wr_strobe_t dev_strobe;
  i2c_port_pkg::rd_done_t   rd_done;
  i2c_port_pkg::reg_view_t  view;  // shared by both read muxes

  host_port u_host_port (
    .clk        (clk),
    .rst        (rst),
    .host_req_i (host_req_i),
    .view_i     (view),
    .strobe_o   (host_strobe),
    .rd_done_o  (rd_done.host),
    .rdata_o    (host_rdata_o)
  );

  dev_port u_dev_port (
    .clk       (clk),
    .rst       (rst),
    .dev_req_i (dev_req_i),
    .view_i    (view),
    .strobe_o  (dev_strobe),
    .rd_done_o (rd_done.dev),
    .rdata_o   (dev_rdata_o)
  );

  reg_file u_reg_file (
    .clk            (clk),
    .rst            (rst),
    .host_strobe_i  (host_strobe),
    .dev_strobe_i   (dev_strobe),
    .host_rd_done_i (rd_done.host),
    .dev_rd_done_i  (rd_done.dev),
    .view_o         (view),
    .cfg_o          (cfg_o),
    .host_irq_o     (host_irq_o),
    .dev_irq_o      (i2c_irq_o)  // device side interrupt
  );

endmodule

// ==== bench/i2c_periph_regs_sva.sv ====
`timescale 1ns/1ps

module i2c_periph_regs_sva (
  input logic                     clk,
  input logic                     rst,
  input logic                     host_msg_wr_i,  // host posts to the device mailbox
  input logic                     dev_msg_wr_i,
  input logic                     host_irq_en_wr_i,
  input logic                     dev_irq_en_wr_i,
  input logic                     host_rd_done_i,
  input logic                     dev_rd_done_i,
  input logic                     to_host_full_i,
  input logic                     to_dev_full_i,
  input logic                     host_irq_i,
  input logic                     dev_irq_i,
  input i2c_regmap_pkg::i2c_cfg_t cfg_i
);

  // an interrupt only moves after a message, a consume or an enable write
  host_irq_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(host_irq_i) |-> $past(dev_msg_wr_i || host_irq_en_wr_i))
    else $error("host interrupt rose without a message or enable write");

  host_irq_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(host_irq_i) |-> $past(host_rd_done_i || host_irq_en_wr_i))
    else $error("host interrupt fell without a read done or enable write");

  dev_irq_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(dev_irq_i) |-> $past(host_msg_wr_i || dev_irq_en_wr_i))
    else $error("device interrupt rose without a message or enable write");

  dev_irq_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(dev_irq_i) |-> $past(dev_rd_done_i || dev_irq_en_wr_i))
    else $error("device interrupt fell without a read done or enable write");

  // a flag may only rise right after its own mailbox write
  to_host_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(to_host_full_i) |-> $past(dev_msg_wr_i))
    else $error("message to host flag rose without a device write");

  to_dev_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(to_dev_full_i) |-> $past(host_msg_wr_i))
    else $error("message to device flag rose without a host write");

  cfg_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> (cfg_i == i2c_regmap_pkg::RESET_CFG))
    else $error("configuration not at defaults after reset");

endmodule

bind reg_file i2c_periph_regs_sva u_sva (
  .clk              (clk),
  .rst              (rst),
  .host_msg_wr_i    (host_strobe_i.msg),
  .dev_msg_wr_i     (dev_strobe_i.msg),
  .host_irq_en_wr_i (host_strobe_i.irq_en),
  .dev_irq_en_wr_i  (dev_strobe_i.irq_en),
  .host_rd_done_i   (host_rd_done_i),
  .dev_rd_done_i    (dev_rd_done_i),
  .to_host_full_i   (to_host_full),
  .to_dev_full_i    (to_dev_full),
  .host_irq_i       (host_irq_o),
  .dev_irq_i        (dev_irq_o),
  .cfg_i            (cfg_o)
);

// ==== bench/tb_i2c_periph_regs.sv ====
`timescale 1ns/1ps

module tb_i2c_periph_regs;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 5;
  localparam int MAX_TEST_CYCLES = 400;  // the full register sweep is the longest
  localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_TESTS * MAX_TEST_CYCLES) * CLK_PERIOD;

  logic                     clk;
  logic                     rst;
  i2c_port_pkg::host_req_t  host_req;
  i2c_port_pkg::dev_req_t   dev_req;
  logic [31:0]              host_rdata;
  logic [7:0]               dev_rdata;
  i2c_regmap_pkg::i2c_cfg_t cfg;
  logic                     host_irq;
  logic                     i2c_irq;

  logic [31:0] lcg_state;
  logic [7:0]  exp_map [256];  // expected read value per register index
  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          test_err_base;

  i2c_periph_regs_top DUT (
    .clk          (clk),
    .rst          (rst),
    .host_req_i   (host_req),
    .host_rdata_o (host_rdata),
    .dev_req_i    (dev_req),
    .dev_rdata_o  (dev_rdata),
    .cfg_o        (cfg),
    .host_irq_o   (host_irq),
    .i2c_irq_o    (i2c_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("Verification failed");
    $finish;
  end

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic i2c_port_pkg::host_addr_t word_addr(logic [7:0] idx);
    return {2'b00, idx, 2'b00};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error @ %0t: %s returned 0x%0h, expected 0x%0h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // every task starts and ends one step after a rising edge
  task automatic host_write(input i2c_port_pkg::host_addr_t addr, input logic [7:0] data);
    host_req.waddr = addr;
    host_req.wdata = {24'hC3A55A, data};  // upper lanes are ignored
    host_req.we    = 1'b1;
    @(posedge clk);
    #1;
    host_req.we    = 1'b0;
  endtask

  task automatic host_read(input i2c_port_pkg::host_addr_t addr, output logic [31:0] data);
    host_req.raddr = addr;
    @(posedge clk);
    #1;
    data = host_rdata;
  endtask

  task automatic host_read_done(input logic [7:0] idx);
    host_req.raddr   = word_addr(idx);
    host_req.rd_done = 1'b1;
    @(posedge clk);
    #1;
    host_req.rd_done = 1'b0;
  endtask

  task automatic dev_write(input logic [7:0] addr, input logic [7:0] data);
    dev_req.addr  = addr;
    dev_req.wdata = data;
    dev_req.we    = 1'b1;
    @(posedge clk);
    #1;
    dev_req.we    = 1'b0;
  endtask

  task automatic dev_read(input logic [7:0] addr, output logic [7:0] data);
    dev_req.addr = addr;
    @(posedge clk);
    #1;
    data = dev_rdata;
  endtask

  task automatic dev_read_done(input logic [7:0] addr);
    dev_req.addr    = addr;
    dev_req.rd_done = 1'b1;
    @(posedge clk);
    #1;
    dev_req.rd_done = 1'b0;
  endtask

  task automatic expect_host(input logic [7:0] idx);
    logic [31:0] got;
    host_read(word_addr(idx), got);
    check_eq($sformatf("host read 0x%02h", idx), got, {24'h0, exp_map[idx]});
  endtask

  task automatic expect_dev(input logic [7:0] idx);
    logic [7:0] got;
    dev_read(idx, got);
    check_eq($sformatf("device read 0x%02h", idx), {24'h0, got}, {24'h0, exp_map[idx]});
  endtask

  task automatic check_cfg();
    check_eq("cfg_o dev_addr", {25'h0, cfg.dev_addr},
             {24'h0, exp_map[i2c_regmap_pkg::REG_DEV_ADDR]});
    check_eq("cfg_o enable", {31'h0, cfg.enable},
             {24'h0, exp_map[i2c_regmap_pkg::REG_ENABLE]});
    check_eq("cfg_o debounce", {24'h0, cfg.debounce},
             {24'h0, exp_map[i2c_regmap_pkg::REG_DEBOUNCE]});
    check_eq("cfg_o scl_delay", {24'h0, cfg.scl_delay},
             {24'h0, exp_map[i2c_regmap_pkg::REG_SCL_DELAY]});
    check_eq("cfg_o sda_delay", {24'h0, cfg.sda_delay},
             {24'h0, exp_map[i2c_regmap_pkg::REG_SDA_DELAY]});
  endtask

  task automatic check_irqs(input logic exp_host, input logic exp_dev);
    check_eq("host_irq_o", {31'h0, host_irq}, {31'h0, exp_host});
    check_eq("i2c_irq_o", {31'h0, i2c_irq}, {31'h0, exp_dev});
  endtask

  // sweep 0x00..0x5f on both sides, unmapped entries are zero in the model
  task automatic check_all_regs();
    logic [7:0] idx;
    for (int i = 0; i < 96; i++) begin
      idx = i[7:0];
      expect_host(idx);
      expect_dev(idx);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  task automatic test_reset_defaults();
    logic [7:0] idx;
    for (int i = 0; i < 5; i++) begin
      idx = i[7:0];
      expect_host(idx);
    end
    expect_dev(i2c_regmap_pkg::REG_DEV_ADDR);
    check_cfg();
    check_irqs(1'b0, 1'b0);
  endtask

  task automatic test_config_write();
    logic [7:0] idx;
    logic [7:0] val;
    for (int i = 0; i < 5; i++) begin
      idx = i[7:0];
      val = next_rand();
      host_write(word_addr(idx), val);
      case (idx)  // narrow fields keep their low bits
        i2c_regmap_pkg::REG_DEV_ADDR: exp_map[idx] = {1'b0, val[6:0]};
        i2c_regmap_pkg::REG_ENABLE:   exp_map[idx] = {7'h0, val[0]};
        default:                      exp_map[idx] = val;
      endcase
      check_cfg();
      expect_host(idx);
      expect_dev(idx);
    end
    // nonzero bits 11:10 put the address out of range
    host_write({2'b01, i2c_regmap_pkg::REG_DEBOUNCE, 2'b00},
               ~exp_map[i2c_regmap_pkg::REG_DEBOUNCE]);
    host_write({2'b11, i2c_regmap_pkg::REG_SDA_DELAY, 2'b00},
               ~exp_map[i2c_regmap_pkg::REG_SDA_DELAY]);
    check_cfg();
    expect_host(i2c_regmap_pkg::REG_DEBOUNCE);
    expect_host(i2c_regmap_pkg::REG_SDA_DELAY);
  endtask

  task automatic test_msg_to_host();
    logic [7:0] msg;
    msg = next_rand();
    dev_write(i2c_regmap_pkg::REG_MSG_TO_HOST, msg);
    exp_map[i2c_regmap_pkg::REG_MSG_TO_HOST]      = msg;
    exp_map[i2c_regmap_pkg::REG_MSG_TO_HOST_STAT] = 8'h01;
    expect_host(i2c_regmap_pkg::REG_MSG_TO_HOST_STAT);
    expect_host(i2c_regmap_pkg::REG_MSG_TO_HOST);
    check_irqs(1'b0, 1'b0);  // enable still clear
    host_write(word_addr(i2c_regmap_pkg::REG_HOST_IRQ_EN), 8'h01);
    exp_map[i2c_regmap_pkg::REG_HOST_IRQ_EN]   = 8'h01;
    exp_map[i2c_regmap_pkg::REG_HOST_IRQ_STAT] = 8'h01;
    check_irqs(1'b1, 1'b0);
    expect_host(i2c_regmap_pkg::REG_HOST_IRQ_STAT);
    host_read_done(i2c_regmap_pkg::REG_MSG_TO_HOST);
    exp_map[i2c_regmap_pkg::REG_MSG_TO_HOST_STAT] = 8'h00;
    exp_map[i2c_regmap_pkg::REG_HOST_IRQ_STAT]    = 8'h00;
    check_irqs(1'b0, 1'b0);
    expect_host(i2c_regmap_pkg::REG_MSG_TO_HOST_STAT);
    expect_host(i2c_regmap_pkg::REG_HOST_IRQ_STAT);
  endtask

  task automatic test_msg_to_dev();
    logic [7:0] msg;
    msg = next_rand();
    host_write(word_addr(i2c_regmap_pkg::REG_MSG_TO_DEV), msg);
    exp_map[i2c_regmap_pkg::REG_MSG_TO_DEV]      = msg;
    exp_map[i2c_regmap_pkg::REG_MSG_TO_DEV_STAT] = 8'h01;
    expect_dev(i2c_regmap_pkg::REG_MSG_TO_DEV_STAT);
    expect_dev(i2c_regmap_pkg::REG_MSG_TO_DEV);
    check_irqs(1'b0, 1'b0);
    dev_write(i2c_regmap_pkg::REG_DEV_IRQ_EN, 8'h01);
    exp_map[i2c_regmap_pkg::REG_DEV_IRQ_EN]   = 8'h01;
    exp_map[i2c_regmap_pkg::REG_DEV_IRQ_STAT] = 8'h01;
    check_irqs(1'b0, 1'b1);
    expect_dev(i2c_regmap_pkg::REG_DEV_IRQ_STAT);
    dev_read_done(i2c_regmap_pkg::REG_MSG_TO_DEV);
    exp_map[i2c_regmap_pkg::REG_MSG_TO_DEV_STAT] = 8'h00;
    exp_map[i2c_regmap_pkg::REG_DEV_IRQ_STAT]    = 8'h00;
    check_irqs(1'b0, 1'b0);
    expect_dev(i2c_regmap_pkg::REG_MSG_TO_DEV_STAT);
    expect_dev(i2c_regmap_pkg::REG_DEV_IRQ_STAT);
  endtask

  task automatic test_protected_unmapped();
    logic [31:0] host_got;
    logic [7:0]  dev_got;
    host_write(word_addr(i2c_regmap_pkg::REG_DEV_IRQ_STAT), 8'hFF);
    host_write(word_addr(i2c_regmap_pkg::REG_MSG_TO_HOST_STAT), 8'hFF);
    host_write(word_addr(8'h7F), 8'hFF);
    dev_write(i2c_regmap_pkg::REG_DEV_ADDR, ~exp_map[i2c_regmap_pkg::REG_DEV_ADDR]);
    check_cfg();
    check_irqs(1'b0, 1'b0);
    check_all_regs();
    host_read({2'b10, i2c_regmap_pkg::REG_DEV_ADDR, 2'b00}, host_got);  // out of range
    check_eq("host read out of range", host_got, 32'h0);
    host_read(word_addr(8'hFF), host_got);
    check_eq("host read 0xff", host_got, 32'h0);
    dev_read(8'hFF, dev_got);
    check_eq("device read 0xff", {24'h0, dev_got}, 32'h0);
  endtask

  initial begin
    rst           = 1'b1;
    host_req      = '0;
    dev_req       = '0;
    lcg_state     = 32'd45710;
    err_count     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    for (int i = 0; i < 256; i++) begin
      exp_map[i] = 8'h00;
    end
    exp_map[i2c_regmap_pkg::REG_DEV_ADDR]  = 8'h6F;
    exp_map[i2c_regmap_pkg::REG_DEBOUNCE]  = 8'd20;
    exp_map[i2c_regmap_pkg::REG_SCL_DELAY] = 8'd20;
    exp_map[i2c_regmap_pkg::REG_SDA_DELAY] = 8'd8;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_defaults();
    end_test("reset_defaults");
    test_config_write();
    end_test("config_write");
    test_msg_to_host();
    end_test("msg_to_host");
    test_msg_to_dev();
    end_test("msg_to_dev");
    test_protected_unmapped();
    end_test("protected_unmapped");

    $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== i2c_periph_regs.f ====
design/i2c_regmap_pkg.sv
design/i2c_port_pkg.sv
design/msg_mailbox.sv
design/host_port.sv
design/dev_port.sv
design/reg_file.sv
design/i2c_periph_regs_top.sv
bench/i2c_periph_regs_sva.sv
bench/tb_i2c_periph_regs.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert \
  --top-module tb_i2c_periph_regs \
  -Mdir obj_dir \
  -f i2c_periph_regs.f > "$LOG" 2>&1 &&
  ./obj_dir/Vtb_i2c_periph_regs >> "$LOG" 2>&1
cat "$LOG"
grep -q "Verification passed" "$LOG" && echo "simulation PASS" ||
  { echo "simulation FAIL, see $LOG"; exit 1; }
